/* hdl/decode_cfg.svh */
`ifndef DECODE_CFG_SVH
`define DECODE_CFG_SVH

// Data word and bus address widths
`define DEC_DATA_W 32
`define DEC_ADR_W 6

// Register index width
`define DEC_REG_AW 5

// Bundle FIFO entries
`define DEC_FIFO_DEPTH 4

// Slave address that issues an instruction, lower ones hit the register file
`define DEC_INST_ADR 32

// Link register written by jal
`define DEC_LINK_REG 31

`endif

/* hdl/decodePkg.sv */
`default_nettype none

`include "decode_cfg.svh"

package decodePkg;

    // Primary opcode, bits 31:26
    typedef enum logic [5:0] {
        rType = 6'h00,
        bltz  = 6'h01,
        j     = 6'h02,
        jal   = 6'h03,
        beq   = 6'h04,
        bne   = 6'h05,
        bgtz  = 6'h07,
        addi  = 6'h08,
        andi  = 6'h0c,
        ori   = 6'h0d,
        xori  = 6'h0e,
        lui   = 6'h0f
    } instOp_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        fSll = 6'h00,
        fSrl = 6'h02,
        fSra = 6'h03,
        fJr  = 6'h08,
        fAdd = 6'h20,
        fSub = 6'h22,
        fAnd = 6'h24,
        fOr  = 6'h25,
        fXor = 6'h26,
        fSlt = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        opNop,
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt,
        opSll,
        opSrl,
        opSra,
        opPass
    } aluOp_e;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`DEC_ADR_W-1:0]  adr;
        logic [`DEC_DATA_W-1:0] dat;
    } wbReq_t;

    typedef struct packed {
        aluOp_e                 op;
        logic [`DEC_REG_AW-1:0] regcAddr;
        logic                   regcWrite;
        logic [`DEC_DATA_W-1:0] operandA;
        logic [`DEC_DATA_W-1:0] operandB;
        logic [`DEC_DATA_W-1:0] jumpAddr;
        logic                   jumpTaken;
        logic [`DEC_DATA_W-1:0] pc;
    } decodedOp_t;

    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        decodedOp_t dat;
    } wbOut_t;

endpackage

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module regFile (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   we,
    input  wire logic [`DEC_REG_AW-1:0] wAddr,
    input  wire logic [`DEC_DATA_W-1:0] wData,
    input  wire logic [`DEC_REG_AW-1:0] rAddrA,
    input  wire logic [`DEC_REG_AW-1:0] rAddrB,
    output logic      [`DEC_DATA_W-1:0] rDataA,
    output logic      [`DEC_DATA_W-1:0] rDataB
);

    localparam int NumRegs = 1 << `DEC_REG_AW;

    logic [`DEC_DATA_W-1:0] regs [NumRegs];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < NumRegs; i++)
                regs[i] <= '0;
        end
        else if (we && wAddr != '0)
        begin
            regs[wAddr] <= wData;
        end
    end

    // r0 always reads as zero
    assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
    assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

`default_nettype wire

/* hdl/instDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module instDecoder (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire decodePkg::wbReq_t     wbIn,
    output logic                       ack,
    input  wire logic                  fifoFull,
    output logic                       push,
    output decodePkg::decodedOp_t      bundle
);

    localparam logic [`DEC_REG_AW-1:0] LinkReg = `DEC_LINK_REG;

    logic [`DEC_DATA_W-1:0] pc;
    logic [`DEC_DATA_W-1:0] npc;
    logic [`DEC_DATA_W-1:0] inst;
    logic [`DEC_DATA_W-1:0] imm;
    logic [`DEC_DATA_W-1:0] rDataA;
    logic [`DEC_DATA_W-1:0] rDataB;
    logic [`DEC_DATA_W-1:0] branchAddr;
    logic [`DEC_DATA_W-1:0] jumpTarget;
    logic [`DEC_REG_AW-1:0] rs;
    logic [`DEC_REG_AW-1:0] rt;
    logic [`DEC_REG_AW-1:0] rd;
    logic                   regARead;
    logic                   regBRead;
    logic                   sel;
    logic                   isInst;
    logic                   regWe;

    function automatic decodePkg::aluOp_e opFor(input logic [5:0] opcode,
                                                input logic [5:0] funct);
        decodePkg::aluOp_e res;
        res = decodePkg::opNop;
        case (opcode)
            decodePkg::addi: res = decodePkg::opAdd;
            decodePkg::andi: res = decodePkg::opAnd;
            decodePkg::ori:  res = decodePkg::opOr;
            decodePkg::xori: res = decodePkg::opXor;
            decodePkg::lui:  res = decodePkg::opPass;
            decodePkg::jal:  res = decodePkg::opPass;
            decodePkg::rType:
            begin
                case (funct)
                    decodePkg::fAdd: res = decodePkg::opAdd;
                    decodePkg::fSub: res = decodePkg::opSub;
                    decodePkg::fAnd: res = decodePkg::opAnd;
                    decodePkg::fOr:  res = decodePkg::opOr;
                    decodePkg::fXor: res = decodePkg::opXor;
                    decodePkg::fSlt: res = decodePkg::opSlt;
                    decodePkg::fSll: res = decodePkg::opSll;
                    decodePkg::fSrl: res = decodePkg::opSrl;
                    decodePkg::fSra: res = decodePkg::opSra;
                    default:         res = decodePkg::opNop;
                endcase
            end
            default: res = decodePkg::opNop;
        endcase
        return res;
    endfunction

    assign inst = wbIn.dat;
    assign rs   = inst[25:21];
    assign rt   = inst[20:16];
    assign rd   = inst[15:11];

    assign npc        = pc + `DEC_DATA_W'(4);
    assign branchAddr = npc + {{(`DEC_DATA_W-18){inst[15]}}, inst[15:0], 2'b00};
    assign jumpTarget = {npc[`DEC_DATA_W-1 -: 4], inst[25:0], 2'b00};

    // Slave side
    assign sel    = wbIn.cyc && wbIn.stb;
    assign isInst = wbIn.adr == `DEC_INST_ADR;
    assign regWe  = ack && wbIn.we && (wbIn.adr < `DEC_INST_ADR);
    assign push   = ack && wbIn.we && isInst;

    regFile u_regFile (
        .clk    (clk),
        .rstN   (rstN),
        .we     (regWe),
        .wAddr  (wbIn.adr[`DEC_REG_AW-1:0]),
        .wData  (wbIn.dat),
        .rAddrA (rs),
        .rAddrB (rt),
        .rDataA (rDataA),
        .rDataB (rDataB)
    );

    always_comb
    begin
        bundle    = '0;
        bundle.pc = pc;
        bundle.op = opFor(inst[31:26], inst[5:0]);
        regARead  = 1'b0;
        regBRead  = 1'b0;
        imm       = '0;
        case (inst[31:26])
            decodePkg::rType:
            begin
                case (inst[5:0])
                    decodePkg::fAdd, decodePkg::fSub, decodePkg::fAnd,
                    decodePkg::fOr, decodePkg::fXor, decodePkg::fSlt:
                    begin
                        regARead         = 1'b1;
                        regBRead         = 1'b1;
                        bundle.regcWrite = 1'b1;
                        bundle.regcAddr  = rd;
                    end
                    decodePkg::fSll, decodePkg::fSrl, decodePkg::fSra:
                    begin
                        regBRead         = 1'b1;
                        imm              = {{(`DEC_DATA_W-5){1'b0}}, inst[10:6]};
                        bundle.regcWrite = 1'b1;
                        bundle.regcAddr  = rd;
                    end
                    decodePkg::fJr:
                    begin
                        regARead         = 1'b1;
                        bundle.jumpTaken = 1'b1;
                        bundle.jumpAddr  = rDataA;
                    end
                    default:
                    begin
                        regARead = 1'b0;
                    end
                endcase
            end
            decodePkg::addi, decodePkg::andi, decodePkg::ori, decodePkg::xori:
            begin
                regARead         = 1'b1;
                imm              = {{(`DEC_DATA_W-16){1'b0}}, inst[15:0]};
                bundle.regcWrite = 1'b1;
                bundle.regcAddr  = rt;
            end
            decodePkg::lui:
            begin
                imm              = {inst[15:0], {(`DEC_DATA_W-16){1'b0}}};
                bundle.regcWrite = 1'b1;
                bundle.regcAddr  = rt;
            end
            decodePkg::beq, decodePkg::bne:
            begin
                regARead         = 1'b1;
                regBRead         = 1'b1;
                bundle.jumpAddr  = branchAddr;
                bundle.jumpTaken = (inst[31:26] == decodePkg::beq) ? (rDataA == rDataB)
                                                                   : (rDataA != rDataB);
            end
            decodePkg::bgtz, decodePkg::bltz:
            begin
                // Signed test of rs against zero
                regARead         = 1'b1;
                bundle.jumpAddr  = branchAddr;
                bundle.jumpTaken = (inst[31:26] == decodePkg::bgtz) ? ($signed(rDataA) > 0)
                                                                    : ($signed(rDataA) < 0);
            end
            decodePkg::j:
            begin
                bundle.jumpTaken = 1'b1;
                bundle.jumpAddr  = jumpTarget;
            end
            decodePkg::jal:
            begin
                imm              = npc;
                bundle.regcWrite = 1'b1;
                bundle.regcAddr  = LinkReg;
                bundle.jumpTaken = 1'b1;
                bundle.jumpAddr  = jumpTarget;
            end
            default:
            begin
                imm = '0;
            end
        endcase
        bundle.operandA = regARead ? rDataA : imm;
        bundle.operandB = regBRead ? rDataB : imm;
    end

    // Ack one cycle after stb, instructions also wait for FIFO room
    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            ack <= 1'b0;
            pc  <= '0;
        end
        else
        begin
            ack <= sel && !ack && (!isInst || !fifoFull);
            if (push)
                pc <= bundle.jumpTaken ? bundle.jumpAddr : npc;
        end
    end

endmodule

`default_nettype wire

/* hdl/decodeFifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeFifo (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  push,
    input  wire decodePkg::decodedOp_t pushData,
    input  wire logic                  pop,
    output decodePkg::decodedOp_t      popData,
    output logic                       full,
    output logic                       empty
);

    localparam int Depth = `DEC_FIFO_DEPTH;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;
    localparam int CntW  = $clog2(Depth + 1);

    decodePkg::decodedOp_t mem [Depth];

    logic [PtrW-1:0] wrPtr;
    logic [PtrW-1:0] rdPtr;
    logic [CntW-1:0] count;
    logic            doPush;
    logic            doPop;

    assign doPush = push && !full;
    assign doPop  = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (doPush)
            mem[wrPtr] <= pushData;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (doPush)
                wrPtr <= (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            if (doPush && !doPop)
                count <= count + 1'b1;
            else if (doPop && !doPush)
                count <= count - 1'b1;
        end
    end

    assign popData = mem[rdPtr];
    assign full    = count == CntW'(Depth);
    assign empty   = count == '0;

endmodule

`default_nettype wire

/* hdl/wbIssueMaster.sv */
`timescale 1ns/1ps
`default_nettype none

module wbIssueMaster (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  empty,
    input  wire decodePkg::decodedOp_t headData,
    output logic                       pop,
    output decodePkg::wbOut_t          wbOut,
    input  wire logic                  ack
);

    typedef enum logic {
        stIdle,
        stBusy
    } state_e;

    state_e                state;
    decodePkg::decodedOp_t datQ;

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            state <= stIdle;
        end
        else
        begin
            case (state)
                stIdle:
                    if (!empty)
                        state <= stBusy;
                stBusy:
                    if (ack)
                        state <= stIdle;
                default:
                    state <= stIdle;
            endcase
        end
    end

    // Latch the head as the cycle opens
    always_ff @(posedge clk)
    begin
        if (state == stIdle && !empty)
            datQ <= headData;
    end

    // Head leaves the FIFO on the acked beat
    assign pop = (state == stBusy) && ack;

    always_comb
    begin
        wbOut.cyc = state == stBusy;
        wbOut.stb = state == stBusy;
        wbOut.we  = 1'b1;
        wbOut.dat = datQ;
    end

endmodule

`default_nettype wire

/* hdl/decodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeTop (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire decodePkg::wbReq_t wbIn,
    output logic                   wbInAck,
    output decodePkg::wbOut_t      wbOut,
    input  wire logic              wbOutAck
);

    decodePkg::decodedOp_t pushData;
    decodePkg::decodedOp_t headData;
    logic                  push;
    logic                  pop;
    logic                  fifoFull;
    logic                  fifoEmpty;

    instDecoder u_instDecoder (
        .clk      (clk),
        .rstN     (rstN),
        .wbIn     (wbIn),
        .ack      (wbInAck),
        .fifoFull (fifoFull),
        .push     (push),
        .bundle   (pushData)
    );

    decodeFifo u_decodeFifo (
        .clk      (clk),
        .rstN     (rstN),
        .push     (push),
        .pushData (pushData),
        .pop      (pop),
        .popData  (headData),
        .full     (fifoFull),
        .empty    (fifoEmpty)
    );

    wbIssueMaster u_wbIssueMaster (
        .clk      (clk),
        .rstN     (rstN),
        .empty    (fifoEmpty),
        .headData (headData),
        .pop      (pop),
        .wbOut    (wbOut),
        .ack      (wbOutAck)
    );

endmodule

`default_nettype wire

/* testbench/decodeTop_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module decodeTop_assertions (
    input wire logic              clk,
    input wire logic              rstN,
    input wire decodePkg::wbReq_t wbIn,
    input wire logic              wbInAck,
    input wire decodePkg::wbOut_t wbOut,
    input wire logic              wbOutAck
);

    int failCount = 0;

    upAckNeedsStb: assert property (@(posedge clk) disable iff (!rstN)
        wbInAck |-> (wbIn.cyc && wbIn.stb))
    else
    begin
        $error("Upstream ack seen without an open strobe");
        failCount++;
    end

    // A waiting master keeps its bundle steady
    downDatStable: assert property (@(posedge clk) disable iff (!rstN)
        (wbOut.stb && !wbOutAck) |=> (wbOut.stb && $stable(wbOut.dat)))
    else
    begin
        $error("Downstream strobe or data changed before ack");
        failCount++;
    end

    noStbInReset: assert property (@(posedge clk)
        !rstN |=> !wbOut.stb)
    else
    begin
        $error("Downstream strobe high right after a reset cycle");
        failCount++;
    end

endmodule

bind decodeTop decodeTop_assertions u_assertions (
    .clk      (clk),
    .rstN     (rstN),
    .wbIn     (wbIn),
    .wbInAck  (wbInAck),
    .wbOut    (wbOut),
    .wbOutAck (wbOutAck)
);

`default_nettype wire

/* testbench/decodeChecker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module decodeChecker (
    input  wire logic              clk,
    input  wire logic              rstN,
    input  wire decodePkg::wbReq_t wbIn,
    input  wire logic              wbInAck,
    input  wire decodePkg::wbOut_t wbOut,
    input  wire logic              wbOutAck,
    output int                     mismatches,
    output int                     protoErrors,
    output int                     pending,
    output int                     checked
);

    logic [`DEC_DATA_W-1:0] modelRegs [32];
    logic [`DEC_DATA_W-1:0] modelPc;
    decodePkg::decodedOp_t  expQ [$];
    string                  testQ [$];
    decodePkg::decodedOp_t  nextExp;
    string                  nextTest;
    int                     mismatchCnt = 0;
    int                     protoCnt = 0;
    int                     checkedCnt = 0;
    int                     pendingCnt = 0;

    assign mismatches  = mismatchCnt;
    assign protoErrors = protoCnt;
    assign pending     = pendingCnt;
    assign checked     = checkedCnt;

    function automatic logic [31:0] regValue(input logic [4:0] idx);
        return (idx == 5'd0) ? 32'd0 : modelRegs[idx];
    endfunction

    // Expected bundle from the decode rules and the mirrored state
    task automatic predict(input logic [31:0] inst, output decodePkg::decodedOp_t e,
                           output string test);
        logic [31:0]       rsVal;
        logic [31:0]       rtVal;
        logic [31:0]       link;
        logic [31:0]       target;
        logic [5:0]        opc;
        decodePkg::aluOp_e rOp;
        opc    = inst[31:26];
        rsVal  = regValue(inst[25:21]);
        rtVal  = regValue(inst[20:16]);
        link   = modelPc + 32'd4;
        target = {link[31:28], inst[25:0], 2'b00};
        e      = '0;
        e.pc   = modelPc;
        test   = "unknown";
        case (opc)
            decodePkg::rType:
            begin
                case (inst[5:0])
                    decodePkg::fAdd: rOp = decodePkg::opAdd;
                    decodePkg::fSub: rOp = decodePkg::opSub;
                    decodePkg::fAnd: rOp = decodePkg::opAnd;
                    decodePkg::fOr:  rOp = decodePkg::opOr;
                    decodePkg::fXor: rOp = decodePkg::opXor;
                    decodePkg::fSlt: rOp = decodePkg::opSlt;
                    decodePkg::fSll: rOp = decodePkg::opSll;
                    decodePkg::fSrl: rOp = decodePkg::opSrl;
                    decodePkg::fSra: rOp = decodePkg::opSra;
                    default:         rOp = decodePkg::opNop;
                endcase
                if (inst[5:0] == decodePkg::fJr)
                begin
                    test        = "jr";
                    e.operandA  = rsVal;
                    e.jumpTaken = 1'b1;
                    e.jumpAddr  = rsVal;
                end
                else if (rOp != decodePkg::opNop)
                begin
                    e.op        = rOp;
                    e.regcWrite = 1'b1;
                    e.regcAddr  = inst[15:11];
                    e.operandB  = rtVal;
                    if (rOp == decodePkg::opSll || rOp == decodePkg::opSrl ||
                        rOp == decodePkg::opSra)
                    begin
                        test       = "shift";
                        e.operandA = {27'd0, inst[10:6]};
                    end
                    else
                    begin
                        test       = "aluR";
                        e.operandA = rsVal;
                    end
                end
            end
            decodePkg::addi, decodePkg::andi, decodePkg::ori, decodePkg::xori:
            begin
                test = "aluI";
                case (opc)
                    decodePkg::addi: e.op = decodePkg::opAdd;
                    decodePkg::andi: e.op = decodePkg::opAnd;
                    decodePkg::ori:  e.op = decodePkg::opOr;
                    default:         e.op = decodePkg::opXor;
                endcase
                e.regcWrite = 1'b1;
                e.regcAddr  = inst[20:16];
                e.operandA  = rsVal;
                e.operandB  = {16'd0, inst[15:0]};
            end
            decodePkg::lui:
            begin
                test        = "lui";
                e.op        = decodePkg::opPass;
                e.regcWrite = 1'b1;
                e.regcAddr  = inst[20:16];
                e.operandA  = {inst[15:0], 16'd0};
                e.operandB  = {inst[15:0], 16'd0};
            end
            decodePkg::beq, decodePkg::bne, decodePkg::bgtz, decodePkg::bltz:
            begin
                test       = "branch";
                e.operandA = rsVal;
                e.jumpAddr = link + {{14{inst[15]}}, inst[15:0], 2'b00};
                if (opc == decodePkg::beq || opc == decodePkg::bne)
                    e.operandB = rtVal;
                case (opc)
                    decodePkg::beq:  e.jumpTaken = (rsVal == rtVal);
                    decodePkg::bne:  e.jumpTaken = (rsVal != rtVal);
                    decodePkg::bgtz: e.jumpTaken = ($signed(rsVal) > 0);
                    default:         e.jumpTaken = ($signed(rsVal) < 0);
                endcase
            end
            decodePkg::j:
            begin
                test        = "jump";
                e.jumpTaken = 1'b1;
                e.jumpAddr  = target;
            end
            decodePkg::jal:
            begin
                test        = "link";
                e.op        = decodePkg::opPass;
                e.regcWrite = 1'b1;
                e.regcAddr  = 5'(`DEC_LINK_REG);
                e.operandA  = link;
                e.operandB  = link;
                e.jumpTaken = 1'b1;
                e.jumpAddr  = target;
            end
            default:
            begin
                test = "unknown";
            end
        endcase
    endtask

    task automatic checkField(input string test, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        if (expVal !== actVal)
        begin
            $display("FAILED %s.%s: expected %h actual %h", test, field, expVal, actVal);
            mismatchCnt++;
        end
    endtask

    task automatic compareHead(input decodePkg::decodedOp_t act);
        decodePkg::decodedOp_t expB;
        string                 test;
        if (expQ.size() == 0)
        begin
            $display("Downstream bundle with pc %h arrived with no instruction outstanding",
                     act.pc);
            protoCnt++;
        end
        else
        begin
            expB = expQ.pop_front();
            test = testQ.pop_front();
            checkField(test, "op", 32'(expB.op), 32'(act.op));
            checkField(test, "regcAddr", 32'(expB.regcAddr), 32'(act.regcAddr));
            checkField(test, "regcWrite", 32'(expB.regcWrite), 32'(act.regcWrite));
            checkField(test, "operandA", expB.operandA, act.operandA);
            checkField(test, "operandB", expB.operandB, act.operandB);
            checkField(test, "jumpAddr", expB.jumpAddr, act.jumpAddr);
            checkField(test, "jumpTaken", 32'(expB.jumpTaken), 32'(act.jumpTaken));
            checkField(test, "pc", expB.pc, act.pc);
            checkedCnt++;
        end
    endtask

    always @(posedge clk)
    begin
        if (!rstN)
        begin
            foreach (modelRegs[i])
                modelRegs[i] = '0;
            modelPc = '0;
            expQ.delete();
            testQ.delete();
        end
        else
        begin
            if (wbOut.stb && wbOutAck)
            begin
                // Classic write cycle needs cyc and we along with stb
                if (!wbOut.cyc || !wbOut.we)
                begin
                    $display("Downstream transfer acked without cyc and we both high");
                    protoCnt++;
                end
                compareHead(wbOut.dat);
            end
            if (wbIn.cyc && wbIn.stb && wbIn.we && wbInAck)
            begin
                if (wbIn.adr == 6'(`DEC_INST_ADR))
                begin
                    predict(wbIn.dat, nextExp, nextTest);
                    expQ.push_back(nextExp);
                    testQ.push_back(nextTest);
                    modelPc = nextExp.jumpTaken ? nextExp.jumpAddr : modelPc + 32'd4;
                end
                // Writes to r0 are dropped
                else if (wbIn.adr < 6'(`DEC_INST_ADR) && wbIn.adr[4:0] != 5'd0)
                begin
                    modelRegs[wbIn.adr[4:0]] = wbIn.dat;
                end
            end
        end
        pendingCnt <= expQ.size();
    end

endmodule

`default_nettype wire

/* testbench/tbDecodeTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "decode_cfg.svh"

module tbDecodeTop;

    localparam int Seed         = 32'h62c5_47b4;
    localparam int NumRegLoads  = 40;
    localparam int NumTransfers = 400;
    localparam int AckTimeout   = 200;
    localparam int DrainTimeout = 500;

    localparam logic [5:0] Functs [10] = '{
        decodePkg::fAdd, decodePkg::fSub, decodePkg::fAnd, decodePkg::fOr, decodePkg::fXor,
        decodePkg::fSlt, decodePkg::fSll, decodePkg::fSrl, decodePkg::fSra, decodePkg::fJr
    };
    localparam logic [5:0] Opcodes [11] = '{
        decodePkg::addi, decodePkg::andi, decodePkg::ori, decodePkg::xori, decodePkg::lui,
        decodePkg::beq, decodePkg::bne, decodePkg::bgtz, decodePkg::bltz, decodePkg::j,
        decodePkg::jal
    };

    logic              clk = 1'b0;
    logic              rstN = 1'b0;
    decodePkg::wbReq_t wbIn = '0;
    logic              wbInAck;
    decodePkg::wbOut_t wbOut;
    logic              wbOutAck = 1'b0;

    int stimSeed = Seed;
    int ackSeed = ~Seed;
    int ackDelay = 0;
    int ackWait = 0;
    int otherErrors = 0;
    int issued = 0;
    int n;
    bit timedOut = 1'b0;
    int mismatches;
    int protoErrors;
    int pending;
    int checked;

    decodeTop u_dut (
        .clk      (clk),
        .rstN     (rstN),
        .wbIn     (wbIn),
        .wbInAck  (wbInAck),
        .wbOut    (wbOut),
        .wbOutAck (wbOutAck)
    );

    decodeChecker u_checker (
        .clk         (clk),
        .rstN        (rstN),
        .wbIn        (wbIn),
        .wbInAck     (wbInAck),
        .wbOut       (wbOut),
        .wbOutAck    (wbOutAck),
        .mismatches  (mismatches),
        .protoErrors (protoErrors),
        .pending     (pending),
        .checked     (checked)
    );

    initial
    begin
        forever #50 clk = ~clk;
    end

    // Downstream slave, acks 0 to 5 cycles after it sees stb
    always @(posedge clk)
    begin
        if (!rstN || wbOutAck)
        begin
            wbOutAck <= 1'b0;
            ackWait  <= 0;
            ackDelay <= $unsigned($random(ackSeed)) % 6;
        end
        else if (wbOut.cyc && wbOut.stb)
        begin
            if (ackWait >= ackDelay)
                wbOutAck <= 1'b1;
            else
                ackWait <= ackWait + 1;
        end
    end

    task automatic busWrite(input logic [5:0] adr, input logic [31:0] dat);
        int waited;
        bit gotAck;
        waited = 0;
        gotAck = 1'b0;
        @(posedge clk);
        wbIn.cyc <= 1'b1;
        wbIn.stb <= 1'b1;
        wbIn.we  <= 1'b1;
        wbIn.adr <= adr;
        wbIn.dat <= dat;
        while (!gotAck && waited < AckTimeout)
        begin
            @(posedge clk);
            if (wbInAck)
                gotAck = 1'b1;
            else
                waited++;
        end
        if (gotAck)
        begin
            wbIn.cyc <= 1'b0;
            wbIn.stb <= 1'b0;
            wbIn.we  <= 1'b0;
        end
        else
        begin
            $display("Timeout: no upstream ack for address %0d within %0d cycles", adr,
                     AckTimeout);
            otherErrors++;
            timedOut = 1'b1;
        end
    endtask

    task automatic loadRandomReg();
        logic [31:0] dat;
        logic [5:0]  adr;
        dat = $random(stimSeed);
        adr = {1'b0, 5'($random(stimSeed))};
        if (($random(stimSeed) & 7) == 0)
            dat = '0;
        busWrite(adr, dat);
    endtask

    function automatic logic [31:0] randomInst();
        logic [31:0] inst;
        int          pick;
        inst = $random(stimSeed);
        pick = $unsigned($random(stimSeed)) % 24;
        if (pick < 10)
        begin
            inst[31:26] = decodePkg::rType;
            inst[5:0]   = Functs[pick];
        end
        else if (pick < 21)
            inst[31:26] = Opcodes[pick - 10];
        else if (pick == 21)
            inst[31:26] = 6'h23;
        else if (pick == 22)
            {inst[31:26], inst[5:0]} = {decodePkg::rType, 6'h18};
        else
            inst[31:26] = 6'h3f;
        // Equal sources now and then so beq gets taken
        if (($random(stimSeed) & 3) == 0)
            inst[20:16] = inst[25:21];
        return inst;
    endfunction

    task automatic drainBundles();
        int waited;
        waited = 0;
        @(posedge clk);
        while ((pending != 0 || wbOut.stb) && waited < DrainTimeout)
        begin
            @(posedge clk);
            waited++;
        end
        if (pending != 0 || wbOut.stb)
        begin
            $display("Timeout: %0d bundles still outstanding after %0d cycles", pending,
                     DrainTimeout);
            otherErrors++;
            timedOut = 1'b1;
        end
    endtask

    initial
    begin
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        for (n = 0; n < NumRegLoads && !timedOut; n++)
            loadRandomReg();
        for (n = 0; n < NumTransfers && !timedOut; n++)
        begin
            if (($random(stimSeed) & 3) == 0)
                loadRandomReg();
            else
            begin
                busWrite(6'(`DEC_INST_ADR), randomInst());
                if (!timedOut)
                    issued++;
            end
        end
        if (!timedOut)
            drainBundles();
        if (!timedOut && checked != issued)
        begin
            $display("Issued %0d instructions but %0d bundles came out", issued, checked);
            otherErrors++;
        end
        $display("Error counts: mismatches %0d, protocol %0d, other %0d, assertions %0d",
                 mismatches, protoErrors, otherErrors, u_dut.u_assertions.failCount);
        if (mismatches == 0 && protoErrors == 0 && otherErrors == 0 &&
            u_dut.u_assertions.failCount == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+hdl
hdl/decodePkg.sv
hdl/regFile.sv
hdl/instDecoder.sv
hdl/decodeFifo.sv
hdl/wbIssueMaster.sv
hdl/decodeTop.sv
testbench/decodeTop_assertions.sv
testbench/decodeChecker.sv
testbench/tbDecodeTop.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tbDecodeTop -f tb.f -o simDecode; then
    echo "Verilator build failed"
    exit 1
fi

if ! output=$(./obj_dir/simDecode); then
    echo "$output"
    echo "Simulation exited with an error status"
    exit 1
fi

echo "$output"

if echo "$output" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
